/* source/cpu8_defines.svh */
`ifndef CPU8_DEFINES_SVH
`define CPU8_DEFINES_SVH

// --------------------
// Widths
// --------------------

// Data word and register contents
`define CPU8_DATA_W 8
// Program counter, 1024-word instruction space
`define CPU8_PC_W 10
// Instruction word
`define CPU8_INSTR_W 16
// Opcode field at the top of the word
`define CPU8_OPC_W 5
// Register address, eight registers
`define CPU8_REG_AW 3
// Data memory address, 256 bytes
`define CPU8_MEM_AW 8

// Register file size
`define CPU8_NUM_REGS 8

// Instructions killed behind a taken branch
`define CPU8_SQUASH_DEPTH 3

// --------------------
// Opcodes
// --------------------

// Arithmetic and bitwise
`define CPU8_OPC_ADD 5'h01
`define CPU8_OPC_SUB 5'h02
`define CPU8_OPC_SHL 5'h06
`define CPU8_OPC_AND 5'h0a
`define CPU8_OPC_OR 5'h0b
`define CPU8_OPC_NOT 5'h0c
// Memory access
`define CPU8_OPC_LOAD 5'h08
`define CPU8_OPC_STORE 5'h09
// Compare and control flow
`define CPU8_OPC_JMP 5'h07
`define CPU8_OPC_COMPARE 5'h0d
`define CPU8_OPC_JMPGT 5'h0e
`define CPU8_OPC_JMPLT 5'h0f
`define CPU8_OPC_JMPEQ 5'h10

`endif

/* source/cpu8_pkg.sv */
`default_nettype none

`include "cpu8_defines.svh"

package cpu8_pkg;

	// --------------------
	// Instruction word
	// --------------------

	// One word, four readings, chosen by the opcode
	typedef union packed {
		// ALU ops, res_reg <= op1_r (op) op2_r
		struct packed {
			logic [`CPU8_OPC_W-1:0] opcode;
			logic [`CPU8_REG_AW-1:0] res_reg;
			logic spare_hi;
			logic [`CPU8_REG_AW-1:0] op2_r;
			logic spare_lo;
			logic [`CPU8_REG_AW-1:0] op1_r;
		} alu;
		// LOAD, absolute byte address in the low half
		struct packed {
			logic [`CPU8_OPC_W-1:0] opcode;
			logic [`CPU8_REG_AW-1:0] res_reg;
			logic [`CPU8_MEM_AW-1:0] addr;
		} load;
		// STORE, address sits above the source register
		struct packed {
			logic [`CPU8_OPC_W-1:0] opcode;
			logic [`CPU8_MEM_AW-1:0] addr;
			logic [`CPU8_REG_AW-1:0] op1_r;
		} store;
		// Jumps, absolute 10-bit target
		struct packed {
			logic [`CPU8_OPC_W-1:0] opcode;
			logic spare;
			logic [`CPU8_PC_W-1:0] target;
		} branch;
	} instr_u;

	// --------------------
	// Control
	// --------------------

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_or,
		alu_not,
		alu_shl,
		alu_pass
	} alu_op_e;

	// Jump condition kinds
	typedef enum logic [2:0] {
		jump_none,
		jump_always,
		jump_gt,
		jump_lt,
		jump_eq
	} jump_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic op2_invert;
		logic carry_in;
		logic is_load;
		logic is_store;
		logic is_compare;
		logic reg_write;
		jump_e jump;
	} ctrl_t;

	// --------------------
	// Stage buses
	// --------------------

	// Register file write, also the forwarding source
	typedef struct packed {
		logic en;
		logic [`CPU8_REG_AW-1:0] addr;
		logic [`CPU8_DATA_W-1:0] data;
	} rf_write_t;

	typedef struct packed {
		logic taken;
		logic [`CPU8_PC_W-1:0] target;
	} redirect_t;

	// Unsigned compare result
	typedef struct packed {
		logic gt;
		logic lt;
		logic eq;
	} flags_t;

	typedef struct packed {
		logic valid;
		logic [`CPU8_DATA_W-1:0] result;
		logic [`CPU8_REG_AW-1:0] dest;
		logic [`CPU8_MEM_AW-1:0] mem_addr;
		logic is_load;
		logic is_store;
		logic reg_write;
		logic is_compare;
		flags_t flags;
	} ex_wb_t;

endpackage

`default_nettype wire

/* source/cpu8_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_defines.svh"

module cpu8_fetch (
	input logic clk,
	input logic reset,
	input cpu8_pkg::redirect_t redirect,
	output logic [`CPU8_PC_W-1:0] imem_addr,
	input cpu8_pkg::instr_u imem_data,
	output cpu8_pkg::instr_u instr,
	output logic instr_valid
);

	// --------------------
	// Program counter
	// --------------------

	// imem_addr is the PC itself
	// Redirect comes from writeback, target shows up next cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			imem_addr <= '0;
		else if (redirect.taken)
			imem_addr <= redirect.target;
		else
			imem_addr <= imem_addr + 1'b1;
	end

	// --------------------
	// Instruction register
	// --------------------

	// Word captured every cycle, no stalls
	// Valid bit dropped for the word fetched under a redirect
	always_ff @(posedge clk)
	begin
		instr <= imem_data;
		if (reset)
			instr_valid <= 1'b0;
		else
			instr_valid <= !redirect.taken;
	end

endmodule

`default_nettype wire

/* source/cpu8_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_defines.svh"

module cpu8_regfile (
	input logic clk,
	input logic [`CPU8_REG_AW-1:0] rd1_addr,
	input logic [`CPU8_REG_AW-1:0] rd2_addr,
	output logic [`CPU8_DATA_W-1:0] rd1_data,
	output logic [`CPU8_DATA_W-1:0] rd2_data,
	input cpu8_pkg::rf_write_t wr
);

	// Eight general registers, contents undefined after reset
	logic [`CPU8_DATA_W-1:0] regs [`CPU8_NUM_REGS];

	// Two asynchronous read ports for decode
	// Same-cycle writes are covered by decode forwarding, not here
	assign rd1_data = regs[rd1_addr];
	assign rd2_data = regs[rd2_addr];

	// Single write port, end of the writeback cycle
	always_ff @(posedge clk)
	begin
		if (wr.en)
			regs[wr.addr] <= wr.data;
	end

endmodule

`default_nettype wire

/* source/cpu8_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_defines.svh"

module cpu8_decode (
	input logic clk,
	input logic reset,
	input cpu8_pkg::redirect_t redirect,
	input cpu8_pkg::instr_u instr,
	input logic instr_valid,
	output logic [`CPU8_REG_AW-1:0] rd1_addr,
	output logic [`CPU8_REG_AW-1:0] rd2_addr,
	input logic [`CPU8_DATA_W-1:0] rd1_data,
	input logic [`CPU8_DATA_W-1:0] rd2_data,
	input cpu8_pkg::rf_write_t wb_write,
	output cpu8_pkg::ctrl_t ctrl_q,
	output logic [`CPU8_DATA_W-1:0] op1_q,
	output logic [`CPU8_DATA_W-1:0] op2_q,
	output logic [`CPU8_REG_AW-1:0] src1_q,
	output logic [`CPU8_REG_AW-1:0] src2_q,
	output logic [`CPU8_REG_AW-1:0] dest_q,
	output logic [`CPU8_MEM_AW-1:0] mem_addr_q,
	output logic [`CPU8_PC_W-1:0] target_q,
	output logic valid_q
);

	// No-operation control word, also for every unlisted opcode
	localparam cpu8_pkg::ctrl_t ctrl_nop = '{
		alu_op: cpu8_pkg::alu_pass,
		op2_invert: 1'b0,
		carry_in: 1'b0,
		is_load: 1'b0,
		is_store: 1'b0,
		is_compare: 1'b0,
		reg_write: 1'b0,
		jump: cpu8_pkg::jump_none
	};

	cpu8_pkg::ctrl_t ctrl;
	logic [`CPU8_DATA_W-1:0] op1_fwd;
	logic [`CPU8_DATA_W-1:0] op2_fwd;

	// --------------------
	// Field extraction
	// --------------------

	// STORE op1_r shares bits [2:0] with the ALU view
	assign rd1_addr = instr.store.op1_r;
	assign rd2_addr = instr.alu.op2_r;

	// --------------------
	// Opcode decoder
	// --------------------

	always_comb
	begin
		ctrl = ctrl_nop;
		case (instr.alu.opcode)
			`CPU8_OPC_ADD:
			begin
				ctrl.alu_op = cpu8_pkg::alu_add;
				ctrl.reg_write = 1'b1;
			end
			// Subtract as op1 + ~op2 + 1
			`CPU8_OPC_SUB:
			begin
				ctrl.alu_op = cpu8_pkg::alu_add;
				ctrl.op2_invert = 1'b1;
				ctrl.carry_in = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			`CPU8_OPC_AND:
			begin
				ctrl.alu_op = cpu8_pkg::alu_and;
				ctrl.reg_write = 1'b1;
			end
			`CPU8_OPC_OR:
			begin
				ctrl.alu_op = cpu8_pkg::alu_or;
				ctrl.reg_write = 1'b1;
			end
			`CPU8_OPC_NOT:
			begin
				ctrl.alu_op = cpu8_pkg::alu_not;
				ctrl.reg_write = 1'b1;
			end
			`CPU8_OPC_SHL:
			begin
				ctrl.alu_op = cpu8_pkg::alu_shl;
				ctrl.reg_write = 1'b1;
			end
			// Data replaced by memory in writeback
			`CPU8_OPC_LOAD:
			begin
				ctrl.is_load = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			// Store data is op1 + 0 through the adder
			`CPU8_OPC_STORE:
			begin
				ctrl.alu_op = cpu8_pkg::alu_add;
				ctrl.is_store = 1'b1;
			end
			// Subtract, flags only, no register write
			`CPU8_OPC_COMPARE:
			begin
				ctrl.alu_op = cpu8_pkg::alu_add;
				ctrl.op2_invert = 1'b1;
				ctrl.carry_in = 1'b1;
				ctrl.is_compare = 1'b1;
			end
			`CPU8_OPC_JMP: ctrl.jump = cpu8_pkg::jump_always;
			`CPU8_OPC_JMPGT: ctrl.jump = cpu8_pkg::jump_gt;
			`CPU8_OPC_JMPLT: ctrl.jump = cpu8_pkg::jump_lt;
			`CPU8_OPC_JMPEQ: ctrl.jump = cpu8_pkg::jump_eq;
			default: ctrl = ctrl_nop;
		endcase
	end

	// --------------------
	// Decode forwarding
	// --------------------

	// Writeback result two instructions ahead, not yet in the register file
	assign op1_fwd = (wb_write.en && wb_write.addr == rd1_addr) ? wb_write.data : rd1_data;
	assign op2_fwd = (wb_write.en && wb_write.addr == rd2_addr) ? wb_write.data : rd2_data;

	// --------------------
	// Decode/execute registers
	// --------------------

	always_ff @(posedge clk)
	begin
		op1_q <= op1_fwd;
		op2_q <= op2_fwd;
		src1_q <= rd1_addr;
		src2_q <= rd2_addr;
		dest_q <= instr.alu.res_reg;
		// LOAD and STORE keep their address in different bits
		mem_addr_q <= ctrl.is_store ? instr.store.addr : instr.load.addr;
		target_q <= instr.branch.target;
		if (reset)
		begin
			ctrl_q <= ctrl_nop;
			valid_q <= 1'b0;
		end
		else
		begin
			ctrl_q <= ctrl;
			valid_q <= instr_valid && !redirect.taken;
		end
	end

endmodule

`default_nettype wire

/* source/cpu8_execute.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_defines.svh"

module cpu8_execute (
	input logic clk,
	input logic reset,
	input cpu8_pkg::ctrl_t ctrl,
	input logic [`CPU8_DATA_W-1:0] op1,
	input logic [`CPU8_DATA_W-1:0] op2,
	input logic [`CPU8_REG_AW-1:0] src1,
	input logic [`CPU8_REG_AW-1:0] src2,
	input logic [`CPU8_REG_AW-1:0] dest,
	input logic [`CPU8_MEM_AW-1:0] mem_addr,
	input logic [`CPU8_PC_W-1:0] target,
	input logic valid,
	input cpu8_pkg::rf_write_t wb_write,
	input cpu8_pkg::flags_t flags_now,
	output cpu8_pkg::ex_wb_t ex_wb,
	output cpu8_pkg::redirect_t redirect
);

	logic [`CPU8_DATA_W-1:0] opa;
	logic [`CPU8_DATA_W-1:0] opb_fwd;
	logic [`CPU8_DATA_W-1:0] opb;
	logic [`CPU8_DATA_W-1:0] sum;
	logic carry;
	logic [`CPU8_DATA_W-1:0] result;
	cpu8_pkg::flags_t flags_ex;
	logic take;

	// --------------------
	// Execute forwarding
	// --------------------

	// Result of the instruction right ahead, now in writeback
	// Newer than anything decode forwarded, so it wins
	assign opa = (wb_write.en && wb_write.addr == src1) ? wb_write.data : op1;
	assign opb_fwd = (wb_write.en && wb_write.addr == src2) ? wb_write.data : op2;

	// Operand 2 prep
	always_comb
	begin
		if (ctrl.is_store)
			opb = '0;
		else if (ctrl.op2_invert)
			opb = ~opb_fwd;
		else
			opb = opb_fwd;
	end

	// --------------------
	// ALU
	// --------------------

	// Adder with carry out, ninth bit feeds compare
	assign {carry, sum} = {1'b0, opa} + {1'b0, opb} + {{`CPU8_DATA_W{1'b0}}, ctrl.carry_in};

	always_comb
	begin
		case (ctrl.alu_op)
			cpu8_pkg::alu_add: result = sum;
			cpu8_pkg::alu_and: result = opa & opb;
			cpu8_pkg::alu_or: result = opa | opb;
			cpu8_pkg::alu_not: result = ~opa;
			// Logical shift, bit 7 lost
			cpu8_pkg::alu_shl: result = {opa[`CPU8_DATA_W-2:0], 1'b0};
			// Pass for LOAD and NOP
			default: result = opa;
		endcase
	end

	// Unsigned compare from op1 - op2
	// Carry set means op1 >= op2
	always_comb
	begin
		flags_ex.eq = (sum == '0);
		flags_ex.gt = carry && !flags_ex.eq;
		flags_ex.lt = !flags_ex.eq && !flags_ex.gt;
	end

	// --------------------
	// Branch decision
	// --------------------

	// Conditions read the newest compare, forwarded by writeback
	always_comb
	begin
		case (ctrl.jump)
			cpu8_pkg::jump_always: take = 1'b1;
			cpu8_pkg::jump_gt: take = flags_now.gt;
			cpu8_pkg::jump_lt: take = flags_now.lt;
			cpu8_pkg::jump_eq: take = flags_now.eq;
			default: take = 1'b0;
		endcase
	end

	// --------------------
	// Execute/writeback registers
	// --------------------

	always_ff @(posedge clk)
	begin
		ex_wb.result <= result;
		ex_wb.dest <= dest;
		ex_wb.mem_addr <= mem_addr;
		ex_wb.is_load <= ctrl.is_load;
		ex_wb.is_store <= ctrl.is_store;
		ex_wb.reg_write <= ctrl.reg_write;
		ex_wb.is_compare <= ctrl.is_compare;
		ex_wb.flags <= flags_ex;
		redirect.target <= target;
		if (reset)
		begin
			ex_wb.valid <= 1'b0;
			redirect.taken <= 1'b0;
		end
		else
		begin
			// Instruction behind a taken branch dies here
			ex_wb.valid <= valid && !redirect.taken;
			redirect.taken <= valid && take && !redirect.taken;
		end
	end

endmodule

`default_nettype wire

/* source/cpu8_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_defines.svh"

module cpu8_writeback (
	input logic clk,
	input logic reset,
	input cpu8_pkg::ex_wb_t ex_wb,
	output logic [`CPU8_MEM_AW-1:0] dmem_rd_addr,
	input logic [`CPU8_DATA_W-1:0] dmem_rd_data,
	output logic dmem_wr_en,
	output logic [`CPU8_MEM_AW-1:0] dmem_wr_addr,
	output logic [`CPU8_DATA_W-1:0] dmem_wr_data,
	output cpu8_pkg::rf_write_t rf_write,
	output cpu8_pkg::flags_t flags_now
);

	cpu8_pkg::flags_t flags_q;
	logic compare_now;

	// --------------------
	// Data memory
	// --------------------

	// Combinational read, same address as the write side
	// A store one cycle earlier is already in memory
	assign dmem_rd_addr = ex_wb.mem_addr;

	// Store data is op1 passed through the adder
	assign dmem_wr_en = ex_wb.valid && ex_wb.is_store;
	assign dmem_wr_addr = ex_wb.mem_addr;
	assign dmem_wr_data = ex_wb.result;

	// --------------------
	// Register write
	// --------------------

	// Loads take memory data, everything else the ALU result
	// Same bus feeds both forwarding points
	always_comb
	begin
		rf_write.en = ex_wb.valid && ex_wb.reg_write;
		rf_write.addr = ex_wb.dest;
		rf_write.data = ex_wb.is_load ? dmem_rd_data : ex_wb.result;
	end

	// --------------------
	// Compare flags
	// --------------------

	assign compare_now = ex_wb.valid && ex_wb.is_compare;

	// Compare in writeback overrides the stored flags
	assign flags_now = compare_now ? ex_wb.flags : flags_q;

	always_ff @(posedge clk)
	begin
		if (reset)
			flags_q <= '0;
		else if (compare_now)
			flags_q <= ex_wb.flags;
	end

endmodule

`default_nettype wire

/* source/cpu8_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_defines.svh"

module cpu8_top (
	input logic clk,
	input logic reset,
	output logic [`CPU8_PC_W-1:0] imem_addr,
	input logic [`CPU8_INSTR_W-1:0] imem_data,
	output logic [`CPU8_MEM_AW-1:0] dmem_rd_addr,
	input logic [`CPU8_DATA_W-1:0] dmem_rd_data,
	output logic dmem_wr_en,
	output logic [`CPU8_MEM_AW-1:0] dmem_wr_addr,
	output logic [`CPU8_DATA_W-1:0] dmem_wr_data
);

	// Fetch to decode
	cpu8_pkg::instr_u instr;
	logic instr_valid;

	// Register file read side
	logic [`CPU8_REG_AW-1:0] rd1_addr;
	logic [`CPU8_REG_AW-1:0] rd2_addr;
	logic [`CPU8_DATA_W-1:0] rd1_data;
	logic [`CPU8_DATA_W-1:0] rd2_data;

	// Decode to execute
	cpu8_pkg::ctrl_t dec_ctrl;
	logic [`CPU8_DATA_W-1:0] dec_op1;
	logic [`CPU8_DATA_W-1:0] dec_op2;
	logic [`CPU8_REG_AW-1:0] dec_src1;
	logic [`CPU8_REG_AW-1:0] dec_src2;
	logic [`CPU8_REG_AW-1:0] dec_dest;
	logic [`CPU8_MEM_AW-1:0] dec_mem_addr;
	logic [`CPU8_PC_W-1:0] dec_target;
	logic dec_valid;

	// Execute and writeback outputs
	cpu8_pkg::ex_wb_t ex_wb;
	cpu8_pkg::redirect_t redirect;
	cpu8_pkg::rf_write_t rf_write;
	cpu8_pkg::flags_t flags_now;

	cpu8_fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.instr(instr),
		.instr_valid(instr_valid)
	);

	// Register block beside the pipeline
	cpu8_regfile u_regfile (
		.clk(clk),
		.rd1_addr(rd1_addr),
		.rd2_addr(rd2_addr),
		.rd1_data(rd1_data),
		.rd2_data(rd2_data),
		.wr(rf_write)
	);

	cpu8_decode u_decode (
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.instr(instr),
		.instr_valid(instr_valid),
		.rd1_addr(rd1_addr),
		.rd2_addr(rd2_addr),
		.rd1_data(rd1_data),
		.rd2_data(rd2_data),
		.wb_write(rf_write),
		.ctrl_q(dec_ctrl),
		.op1_q(dec_op1),
		.op2_q(dec_op2),
		.src1_q(dec_src1),
		.src2_q(dec_src2),
		.dest_q(dec_dest),
		.mem_addr_q(dec_mem_addr),
		.target_q(dec_target),
		.valid_q(dec_valid)
	);

	cpu8_execute u_execute (
		.clk(clk),
		.reset(reset),
		.ctrl(dec_ctrl),
		.op1(dec_op1),
		.op2(dec_op2),
		.src1(dec_src1),
		.src2(dec_src2),
		.dest(dec_dest),
		.mem_addr(dec_mem_addr),
		.target(dec_target),
		.valid(dec_valid),
		.wb_write(rf_write),
		.flags_now(flags_now),
		.ex_wb(ex_wb),
		.redirect(redirect)
	);

	cpu8_writeback u_writeback (
		.clk(clk),
		.reset(reset),
		.ex_wb(ex_wb),
		.dmem_rd_addr(dmem_rd_addr),
		.dmem_rd_data(dmem_rd_data),
		.dmem_wr_en(dmem_wr_en),
		.dmem_wr_addr(dmem_wr_addr),
		.dmem_wr_data(dmem_wr_data),
		.rf_write(rf_write),
		.flags_now(flags_now)
	);

endmodule

`default_nettype wire

/* bench/cpu8_assert.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_defines.svh"

module cpu8_assert (
	input logic clk,
	input logic reset,
	input logic [`CPU8_PC_W-1:0] imem_addr,
	input logic dmem_wr_en,
	input logic [`CPU8_MEM_AW-1:0] dmem_wr_addr,
	input logic redirect_taken
);

	// --------------------
	// Reset behaviour
	// --------------------

	// No store strobe right out of reset
	assert property (@(posedge clk) $fell(reset) |-> !dmem_wr_en)
		else $error("store strobe high in the cycle after reset");

	// --------------------
	// Store bus
	// --------------------

	// Write address must be known whenever the strobe is up
	assert property (@(posedge clk) disable iff (reset) dmem_wr_en |-> !$isunknown(dmem_wr_addr))
		else $error("unknown store address");

	// A store in writeback never coincides with a jump there
	// So fetch just steps on
	assert property (@(posedge clk) disable iff (reset)
		dmem_wr_en && !redirect_taken |=> imem_addr == $past(imem_addr) + 1'b1)
		else $error("program counter did not step after a store");

endmodule

bind cpu8_top cpu8_assert u_cpu8_assert (
	.clk(clk),
	.reset(reset),
	.imem_addr(imem_addr),
	.dmem_wr_en(dmem_wr_en),
	.dmem_wr_addr(dmem_wr_addr),
	.redirect_taken(redirect.taken)
);

`default_nettype wire

/* bench/cpu8_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu8_defines.svh"

module cpu8_tb;

	// Program lengths, timeout budget follows from them
	localparam int NUM_CASES = 8;
	localparam int LEN_ALU = 17;
	localparam int LEN_FWD_MEM = 5;
	localparam int LEN_COMPARE = 3 + NUM_CASES * 10;
	localparam int LEN_JUMP = 8;
	localparam int LEN_NOP = 11;
	localparam int CYCLE_LIMIT = LEN_ALU + LEN_FWD_MEM + LEN_COMPARE + LEN_JUMP + LEN_NOP + 5 * 20;

	logic clk;
	logic reset;
	logic [`CPU8_PC_W-1:0] imem_addr;
	logic [`CPU8_INSTR_W-1:0] imem_data;
	logic [`CPU8_MEM_AW-1:0] dmem_rd_addr;
	logic [`CPU8_DATA_W-1:0] dmem_rd_data;
	logic dmem_wr_en;
	logic [`CPU8_MEM_AW-1:0] dmem_wr_addr;
	logic [`CPU8_DATA_W-1:0] dmem_wr_data;

	// Memory models
	logic [`CPU8_INSTR_W-1:0] imem [1024];
	logic [`CPU8_DATA_W-1:0] dmem [256];

	// Store log and expected stores
	logic [`CPU8_MEM_AW-1:0] log_addr [$];
	logic [`CPU8_DATA_W-1:0] log_data [$];
	logic [`CPU8_MEM_AW-1:0] exp_addr [$];
	logic [`CPU8_DATA_W-1:0] exp_data [$];

	integer seed;
	int prog_len;
	int cycle_count;

	cpu8_top u_cpu8_top (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_rd_addr(dmem_rd_addr),
		.dmem_rd_data(dmem_rd_data),
		.dmem_wr_en(dmem_wr_en),
		.dmem_wr_addr(dmem_wr_addr),
		.dmem_wr_data(dmem_wr_data)
	);

	// 4 ns clock
	always #2 clk = ~clk;

	// Combinational reads
	assign imem_data = imem[imem_addr];
	assign dmem_rd_data = dmem[dmem_rd_addr];

	// Write at the edge, log every store
	always @(posedge clk)
	begin
		if (dmem_wr_en === 1'b1)
		begin
			dmem[dmem_wr_addr] <= dmem_wr_data;
			log_addr.push_back(dmem_wr_addr);
			log_data.push_back(dmem_wr_data);
		end
	end

	// --------------------
	// Timeout
	// --------------------

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the program did not reach its final jump in %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$fatal(1, "timeout");
		end
	end

	// --------------------
	// Helpers
	// --------------------

	task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "mismatch");
		end
	endtask

	// Instruction encoders, opcode in the top five bits
	function automatic logic [15:0] alu_word(input logic [4:0] opc, input logic [2:0] rd,
		input logic [2:0] rs1, input logic [2:0] rs2);
		return {opc, rd, 1'b0, rs2, 1'b0, rs1};
	endfunction

	function automatic logic [15:0] load_word(input logic [2:0] rd, input logic [7:0] addr);
		return {`CPU8_OPC_LOAD, rd, addr};
	endfunction

	function automatic logic [15:0] store_word(input logic [7:0] addr, input logic [2:0] rs);
		return {`CPU8_OPC_STORE, addr, rs};
	endfunction

	function automatic logic [15:0] branch_word(input logic [4:0] opc, input logic [9:0] target);
		return {opc, 1'b0, target};
	endfunction

	task automatic emit(input logic [15:0] word);
		imem[prog_len] = word;
		prog_len = prog_len + 1;
	endtask

	task automatic expect_store(input logic [7:0] addr, input logic [7:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// Opcode 00 fill with the address in the low bits
	task automatic clear_memories();
		for (int i = 0; i < 1024; i++)
			imem[i] = {6'b0, i[9:0]};
		for (int i = 0; i < 256; i++)
			dmem[i] = i[7:0] ^ 8'ha5;
		exp_addr.delete();
		exp_data.delete();
		prog_len = 0;
	endtask

	// Reset, then run until the final self-jump comes back around
	task automatic run_program(input logic [9:0] end_addr);
		logic seen_next;
		logic done;
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		log_addr.delete();
		log_data.delete();
		seen_next = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			@(posedge clk);
			#1;
			if (imem_addr == end_addr + 10'd1)
				seen_next = 1'b1;
			else if (seen_next && imem_addr == end_addr)
				done = 1'b1;
		end
	endtask

	task automatic compare_stores(input string name);
		check_equal({name, " store count"}, log_addr.size(), exp_addr.size());
		foreach (exp_addr[i])
		begin
			check_equal({name, " store address"}, log_addr[i], exp_addr[i]);
			check_equal({name, " store data"}, log_data[i], exp_data[i]);
		end
	endtask

	// --------------------
	// Directed tests
	// --------------------

	// Dependent ALU chain, forwarding at distance 1 to 3
	task automatic forward_alu_chain();
		logic [7:0] r1, r2, r3, r4, r5, r6, r7;
		logic [7:0] d0, d1, d2;
		clear_memories();
		d0 = $random(seed);
		d1 = $random(seed);
		d2 = $random(seed);
		dmem[8'h80] = d0;
		dmem[8'h81] = d1;
		dmem[8'h82] = d2;
		emit(load_word(3'd1, 8'h80));
		emit(load_word(3'd2, 8'h81));
		emit(alu_word(`CPU8_OPC_ADD, 3'd3, 3'd1, 3'd2));
		emit(alu_word(`CPU8_OPC_SUB, 3'd4, 3'd3, 3'd1));
		emit(store_word(8'h00, 3'd4));
		emit(alu_word(`CPU8_OPC_AND, 3'd5, 3'd4, 3'd3));
		emit(alu_word(`CPU8_OPC_OR, 3'd6, 3'd5, 3'd2));
		emit(alu_word(`CPU8_OPC_NOT, 3'd7, 3'd6, 3'd0));
		emit(store_word(8'h01, 3'd7));
		emit(alu_word(`CPU8_OPC_SHL, 3'd1, 3'd7, 3'd0));
		emit(load_word(3'd2, 8'h82));
		emit(alu_word(`CPU8_OPC_ADD, 3'd3, 3'd2, 3'd1));
		emit(store_word(8'h02, 3'd3));
		emit(store_word(8'h03, 3'd5));
		emit(alu_word(`CPU8_OPC_SUB, 3'd4, 3'd3, 3'd7));
		emit(store_word(8'h04, 3'd4));
		emit(branch_word(`CPU8_OPC_JMP, 10'd16));
		// Sequential model
		r1 = d0;
		r2 = d1;
		r3 = r1 + r2;
		r4 = r3 - r1;
		expect_store(8'h00, r4);
		r5 = r4 & r3;
		r6 = r5 | r2;
		r7 = ~r6;
		expect_store(8'h01, r7);
		r1 = {r7[6:0], 1'b0};
		r2 = d2;
		r3 = r2 + r1;
		expect_store(8'h02, r3);
		expect_store(8'h03, r5);
		r4 = r3 - r7;
		expect_store(8'h04, r4);
		run_program(10'd16);
		compare_stores("alu chain");
	endtask

	// Store, load back at once, store again
	task automatic store_then_load();
		logic [7:0] d;
		clear_memories();
		d = $random(seed);
		dmem[8'h80] = d;
		emit(load_word(3'd1, 8'h80));
		emit(store_word(8'h10, 3'd1));
		emit(load_word(3'd2, 8'h10));
		emit(store_word(8'h11, 3'd2));
		emit(branch_word(`CPU8_OPC_JMP, 10'd4));
		expect_store(8'h10, d);
		expect_store(8'h11, d);
		run_program(10'd4);
		compare_stores("store load");
	endtask

	// Unsigned compare then conditional jump, marker per path
	task automatic compare_and_branch();
		logic [7:0] a;
		logic [7:0] b;
		logic [4:0] opc;
		logic taken;
		int base;
		clear_memories();
		dmem[8'hf0] = 8'h3c;
		dmem[8'hf1] = 8'hc3;
		emit(load_word(3'd6, 8'hf0));
		emit(load_word(3'd7, 8'hf1));
		for (int k = 0; k < NUM_CASES; k++)
		begin
			a = $random(seed);
			b = $random(seed);
			if (k == 5 || k == 6)
				b = a;
			dmem[8'h80 + 2 * k] = a;
			dmem[8'h81 + 2 * k] = b;
			base = 2 + k * 10;
			case (k % 3)
				0:
				begin
					opc = `CPU8_OPC_JMPGT;
					taken = a > b;
				end
				1:
				begin
					opc = `CPU8_OPC_JMPLT;
					taken = a < b;
				end
				default:
				begin
					opc = `CPU8_OPC_JMPEQ;
					taken = a == b;
				end
			endcase
			emit(load_word(3'd1, 8'h80 + 2 * k));
			emit(load_word(3'd2, 8'h81 + 2 * k));
			emit(alu_word(`CPU8_OPC_COMPARE, 3'd0, 3'd1, 3'd2));
			emit(branch_word(opc, base + 8));
			// Fall-through path
			emit(store_word(8'h40 + k, 3'd6));
			emit(branch_word(`CPU8_OPC_JMP, base + 9));
			emit(16'h0000);
			emit(16'h0000);
			// Taken path
			emit(store_word(8'h40 + k, 3'd7));
			emit(16'h0000);
			expect_store(8'h40 + k, taken ? 8'hc3 : 8'h3c);
		end
		emit(branch_word(`CPU8_OPC_JMP, prog_len));
		run_program(prog_len - 1);
		compare_stores("compare branch");
	endtask

	// Three words behind a taken jump are squashed
	task automatic squash_after_jump();
		logic [7:0] a;
		logic [7:0] b;
		clear_memories();
		a = $random(seed);
		b = $random(seed);
		dmem[8'h80] = a;
		dmem[8'h81] = b;
		emit(load_word(3'd1, 8'h80));
		emit(load_word(3'd2, 8'h81));
		emit(branch_word(`CPU8_OPC_JMP, 10'd6));
		emit(store_word(8'h20, 3'd1));
		emit(store_word(8'h21, 3'd1));
		emit(store_word(8'h22, 3'd1));
		emit(store_word(8'h23, 3'd2));
		emit(branch_word(`CPU8_OPC_JMP, 10'd7));
		expect_store(8'h23, b);
		run_program(10'd7);
		compare_stores("jump squash");
	endtask

	// Dropped opcodes touch nothing
	task automatic ignore_dropped_opcodes();
		logic [7:0] a;
		logic [7:0] b;
		clear_memories();
		a = $random(seed);
		b = $random(seed);
		dmem[8'h80] = a;
		dmem[8'h81] = b;
		emit(load_word(3'd1, 8'h80));
		emit(load_word(3'd2, 8'h81));
		emit(store_word(8'h30, 3'd1));
		emit(alu_word(5'h03, 3'd1, 3'd2, 3'd2));
		emit(alu_word(5'h04, 3'd2, 3'd1, 3'd1));
		emit(alu_word(5'h05, 3'd1, 3'd2, 3'd1));
		// Old JMPC encoding, target 0
		emit(branch_word(5'h11, 10'd0));
		emit(alu_word(5'h00, 3'd2, 3'd1, 3'd1));
		emit(store_word(8'h31, 3'd1));
		emit(store_word(8'h32, 3'd2));
		emit(branch_word(`CPU8_OPC_JMP, 10'd10));
		expect_store(8'h30, a);
		expect_store(8'h31, a);
		expect_store(8'h32, b);
		run_program(10'd10);
		compare_stores("dropped opcodes");
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		seed = 32'hc998_fda6;
		cycle_count = 0;
		clear_memories();
		forward_alu_chain();
		store_then_load();
		compare_and_branch();
		squash_after_jump();
		ignore_dropped_opcodes();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* cpu8.f */
+incdir+source
source/cpu8_pkg.sv
source/cpu8_fetch.sv
source/cpu8_regfile.sv
source/cpu8_decode.sv
source/cpu8_execute.sv
source/cpu8_writeback.sv
source/cpu8_top.sv
bench/cpu8_assert.sv
bench/cpu8_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, verdict from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu8_tb -f cpu8.f -o cpu8_sim \
	&& ./obj_dir/cpu8_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
grep -q "Everything OK" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
